// ==== rtl/gpu_blend_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_blend_top #(
        parameter int FIFO_DEPTH = 16
) (
        input  wire                  i_wire_clock,
        input  wire                  i_rst_n,

        // blend setup
        input  wire                  i_argb_mode,
        input  wire gpu_pkg::blend_t i_blend,

        // source streams
        input  wire                  i_src1_write,
        input  wire                  i_src2_write,
        input  wire gpu_pkg::pixel_t i_src1_data,
        input  wire gpu_pkg::pixel_t i_src2_data,
        output logic                 o_src1_full,
        output logic                 o_src2_full,

        // blended stream
        input  wire                  i_dst_read,
        output gpu_pkg::pixel_t      o_dst_data,
        output logic                 o_dst_empty
);
        import gpu_pkg::*;

        pixel_t src1_head;
        pixel_t src2_head;
        logic   src1_empty;
        logic   src2_empty;
        logic   src_read;
        pixel_t dst_wdata;
        logic   dst_write;
        logic   dst_almost_full;

        ////////////////////////////////////////
        // source fifos
        ////////////////////////////////////////

        gpu_fifo #(
                .FIFO_DEPTH     (FIFO_DEPTH)
        ) fifo_src1 (
                .i_wire_clock   (i_wire_clock),
                .i_rst_n        (i_rst_n),
                .i_write        (i_src1_write),
                .i_data_in      (i_src1_data),
                .i_read         (src_read),
                .o_data_out     (src1_head),
                .o_full         (o_src1_full),
                .o_almost_full  (),
                .o_empty        (src1_empty)
        );

        gpu_fifo #(
                .FIFO_DEPTH     (FIFO_DEPTH)
        ) fifo_src2 (
                .i_wire_clock   (i_wire_clock),
                .i_rst_n        (i_rst_n),
                .i_write        (i_src2_write),
                .i_data_in      (i_src2_data),
                .i_read         (src_read),
                .o_data_out     (src2_head),
                .o_full         (o_src2_full),
                .o_almost_full  (),
                .o_empty        (src2_empty)
        );

        ////////////////////////////////////////
        // blender
        ////////////////////////////////////////

        // one pop strobe keeps the two streams paired
        gpu_blender blender0 (
                .i_wire_clock      (i_wire_clock),
                .i_rst_n           (i_rst_n),
                .i_argb_mode       (i_argb_mode),
                .i_blend           (i_blend),
                .i_src1_data       (src1_head),
                .i_src2_data       (src2_head),
                .i_src1_empty      (src1_empty),
                .i_src2_empty      (src2_empty),
                .i_dst_almost_full (dst_almost_full),
                .o_src_read        (src_read),
                .o_dst_data        (dst_wdata),
                .o_dst_write       (dst_write)
        );

        ////////////////////////////////////////
        // destination fifo
        ////////////////////////////////////////

        // margin covers the pairs still in the pipeline
        gpu_fifo #(
                .FIFO_DEPTH        (FIFO_DEPTH),
                .ALMOST_FULL_LEVEL (BLEND_LATENCY)
        ) fifo_dst (
                .i_wire_clock      (i_wire_clock),
                .i_rst_n           (i_rst_n),
                .i_write           (dst_write),
                .i_data_in         (dst_wdata),
                .i_read            (i_dst_read),
                .o_data_out        (o_dst_data),
                .o_full            (),
                .o_almost_full     (dst_almost_full),
                .o_empty           (o_dst_empty)
        );

endmodule

`default_nettype wire

// ==== rtl/gpu_blender.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_blender (
        input  wire                  i_wire_clock,
        input  wire                  i_rst_n,

        // blend setup, only changed while idle
        input  wire                  i_argb_mode,
        input  wire gpu_pkg::blend_t i_blend,

        // source fifo heads
        input  wire gpu_pkg::pixel_t i_src1_data,
        input  wire gpu_pkg::pixel_t i_src2_data,
        input  wire                  i_src1_empty,
        input  wire                  i_src2_empty,

        // destination fifo
        input  wire                  i_dst_almost_full,

        output logic                 o_src_read,
        output gpu_pkg::pixel_t      o_dst_data,
        output logic                 o_dst_write
);
        import gpu_pkg::*;

        // blue, green, red
        localparam int CHANNELS = 3;

        logic                     pop;
        channel_t                 factor;
        channel_t                 factor_inv;
        logic [BLEND_LATENCY-1:0] valid_pipe;
        product_t                 prod1_r [CHANNELS];
        product_t                 prod2_r [CHANNELS];
        product_t                 sum [CHANNELS];
        channel_t                 blend_r [CHANNELS];

        ////////////////////////////////////////
        // pop strobe
        ////////////////////////////////////////

        // both sources ready and room for everything in flight
        assign pop        = !i_src1_empty && !i_src2_empty && !i_dst_almost_full;
        assign o_src_read = pop;

        ////////////////////////////////////////
        // stage 1, factor and products
        ////////////////////////////////////////

        // source-1 alpha in argb mode, else the global factor
        assign factor     = i_argb_mode ? i_src1_data[31:24] : i_blend[7:0];
        assign factor_inv = ALPHA_OPAQUE - factor;

        always_ff @(posedge i_wire_clock) begin
                if (pop) begin
                        for (int i = 0; i < CHANNELS; i++) begin
                                prod1_r[i] <= product_t'(i_src1_data[8*i +: 8])
                                              * product_t'(factor);
                                prod2_r[i] <= product_t'(i_src2_data[8*i +: 8])
                                              * product_t'(factor_inv);
                        end
                end
        end

        ////////////////////////////////////////
        // stage 2, sum and shift
        ////////////////////////////////////////

        // at most 255*255, so the sum stays within 16 bits
        always_comb begin
                for (int i = 0; i < CHANNELS; i++) begin
                        sum[i] = prod1_r[i] + prod2_r[i];
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (valid_pipe[0]) begin
                        for (int i = 0; i < CHANNELS; i++) begin
                                // fraction dropped
                                blend_r[i] <= sum[i][15:8];
                        end
                end
        end

        assign o_dst_data = {ALPHA_OPAQUE, blend_r[2], blend_r[1], blend_r[0]};

        ////////////////////////////////////////
        // valid pipe
        ////////////////////////////////////////

        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        valid_pipe <= '0;
                end else begin
                        valid_pipe <= {valid_pipe[BLEND_LATENCY-2:0], pop};
                end
        end

        // written into the destination fifo two edges after the pop
        assign o_dst_write = valid_pipe[BLEND_LATENCY-1];

endmodule

`default_nettype wire

// ==== rtl/gpu_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_fifo #(
        parameter int FIFO_DEPTH        = 16,
        parameter int ALMOST_FULL_LEVEL = 2
) (
        input  wire                  i_wire_clock,
        input  wire                  i_rst_n,

        input  wire                  i_write,
        input  wire gpu_pkg::pixel_t i_data_in,

        input  wire                  i_read,
        output gpu_pkg::pixel_t      o_data_out,

        output logic                 o_full,
        output logic                 o_almost_full,
        output logic                 o_empty
);
        import gpu_pkg::*;

        localparam int ADDR_W = $clog2(FIFO_DEPTH);

        // count thresholds, one bit wider than the address
        localparam logic [ADDR_W:0] COUNT_FULL = (ADDR_W + 1)'(FIFO_DEPTH);
        localparam logic [ADDR_W:0] COUNT_AF   = (ADDR_W + 1)'(FIFO_DEPTH - ALMOST_FULL_LEVEL);

        pixel_t          mem [FIFO_DEPTH];
        logic [ADDR_W:0] wr_ptr;
        logic [ADDR_W:0] rd_ptr;
        logic [ADDR_W:0] count;
        logic            do_write;
        logic            do_read;

        ////////////////////////////////////////
        // accept logic
        ////////////////////////////////////////

        // writes while full and reads while empty are dropped
        assign do_write = i_write && !o_full;
        assign do_read  = i_read && !o_empty;

        ////////////////////////////////////////
        // storage
        ////////////////////////////////////////

        always_ff @(posedge i_wire_clock) begin
                if (do_write) begin
                        mem[wr_ptr[ADDR_W-1:0]] <= i_data_in;
                end
        end

        // first word fall through
        assign o_data_out = mem[rd_ptr[ADDR_W-1:0]];

        ////////////////////////////////////////
        // pointers and fill count
        ////////////////////////////////////////

        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_write) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({do_write, do_read})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // flags
        assign o_empty       = (count == '0);
        assign o_full        = (count == COUNT_FULL);
        assign o_almost_full = (count >= COUNT_AF);

endmodule

`default_nettype wire

// ==== rtl/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

        ////////////////////////////////////////
        // pixel words
        ////////////////////////////////////////

        // argb, alpha in the top byte, then red, green, blue
        typedef logic [31:0] pixel_t;

        // one colour or alpha byte
        typedef logic [7:0] channel_t;

        // channel byte times an 8-bit factor
        typedef logic [15:0] product_t;

        // blend setting word, only the low byte is the factor
        typedef logic [31:0] blend_t;

        ////////////////////////////////////////
        // blend constants
        ////////////////////////////////////////

        localparam int       BLEND_LATENCY = 2;
        localparam channel_t ALPHA_OPAQUE  = 8'hff;

endpackage

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD_NS    = 40,
        parameter int RESET_CYCLES = 3
) (
        output logic o_clk,
        output logic o_rst_n
);
        initial begin
                o_clk = 1'b0;
                forever begin
                        #(PERIOD_NS / 2) o_clk = ~o_clk;
                end
        end

        // reset released on a falling edge, away from the sampling edge
        initial begin
                o_rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge o_clk);
                @(negedge o_clk);
                o_rst_n = 1'b1;
        end

endmodule

`default_nettype wire

// ==== sim/tb_gpu_blend.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_gpu_blend;
        import gpu_pkg::*;

        localparam int RANDOM_PIXELS  = 200;
        localparam int EXTREME_PIXELS = 16;
        localparam int BP_MAX_WRITES  = 64;
        localparam int TOTAL_PIXELS   = 2 * RANDOM_PIXELS + 4 * EXTREME_PIXELS + BP_MAX_WRITES;
        localparam int TIMEOUT_CYCLES = TOTAL_PIXELS * 8 + 1000;

        // cycles with pixels owed and none read before a test gives up
        localparam int STALL_LIMIT    = 64;

        logic   clk;
        logic   rst_n;
        logic   i_argb_mode;
        blend_t i_blend;
        logic   i_src1_write;
        logic   i_src2_write;
        pixel_t i_src1_data;
        pixel_t i_src2_data;
        logic   o_src1_full;
        logic   o_src2_full;
        logic   i_dst_read;
        pixel_t o_dst_data;
        logic   o_dst_empty;

        // model state
        pixel_t src1_q[$];
        pixel_t src2_q[$];
        pixel_t exp_q[$];
        int     test_errors;
        int     tests_passed;
        int     tests_failed;
        int     cycle_count;

        tb_clock_gen #(
                .PERIOD_NS    (40),
                .RESET_CYCLES (3)
        ) clk0 (
                .o_clk   (clk),
                .o_rst_n (rst_n)
        );

        gpu_blend_top #(
                .FIFO_DEPTH (16)
        ) dut0 (
                .i_wire_clock (clk),
                .i_rst_n      (rst_n),
                .i_argb_mode  (i_argb_mode),
                .i_blend      (i_blend),
                .i_src1_write (i_src1_write),
                .i_src2_write (i_src2_write),
                .i_src1_data  (i_src1_data),
                .i_src2_data  (i_src2_data),
                .o_src1_full  (o_src1_full),
                .o_src2_full  (o_src2_full),
                .i_dst_read   (i_dst_read),
                .o_dst_data   (o_dst_data),
                .o_dst_empty  (o_dst_empty)
        );

        ////////////////////////////////////////
        // watchdog
        ////////////////////////////////////////

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        $display("Verification failed");
                        $finish;
                end
        end

        ////////////////////////////////////////
        // reference model and checks
        ////////////////////////////////////////

        // (c1*a + c2*(255-a)) >> 8 per colour byte, alpha opaque
        function automatic pixel_t blend_model(input pixel_t p1, input pixel_t p2,
                                               input logic argb, input blend_t blend);
                int unsigned a;
                int unsigned mix;
                pixel_t      res;
                a = argb ? p1[31:24] : blend[7:0];
                res[31:24] = 8'd255;
                for (int i = 0; i < 3; i++) begin
                        mix = (p1[8*i +: 8] * a + p2[8*i +: 8] * (255 - a)) >> 8;
                        res[8*i +: 8] = mix[7:0];
                end
                return res;
        endfunction

        task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
                if (exp !== act) begin
                        $display("ERR %s: expected %08h, actual %08h", name, exp, act);
                        test_errors++;
                end
        endtask

        task automatic check_flag(input string name, input logic exp, input logic act);
                if (exp !== act) begin
                        $display("ERR %s: expected %0b, actual %0b", name, exp, act);
                        test_errors++;
                end
        endtask

        // pair accepted words in order
        task automatic pair_sources(input logic argb, input blend_t blend);
                while (src1_q.size() > 0 && src2_q.size() > 0) begin
                        exp_q.push_back(blend_model(src1_q.pop_front(), src2_q.pop_front(),
                                                    argb, blend));
                end
        endtask

        task automatic finish_test(input string name);
                i_src1_write = 1'b0;
                i_src2_write = 1'b0;
                i_dst_read   = 1'b0;
                repeat (BLEND_LATENCY + 1) @(negedge clk);
                check_flag({name, " dst empty"}, 1'b1, o_dst_empty);
                if (src1_q.size() != 0 || src2_q.size() != 0 || exp_q.size() != 0) begin
                        $display("test %s: %0d expected pixels never came out of the DUT",
                                 name, exp_q.size());
                        test_errors++;
                end
                // leftovers must not leak into the next test
                src1_q.delete();
                src2_q.delete();
                exp_q.delete();
                if (test_errors == 0) begin
                        $display("test %s: pass", name);
                        tests_passed++;
                end else begin
                        $display("test %s: fail with %0d errors", name, test_errors);
                        tests_failed++;
                end
                test_errors = 0;
        endtask

        ////////////////////////////////////////
        // stimulus
        ////////////////////////////////////////

        // random write strobes on both sources, random reads
        task automatic run_stream(input string name, input logic argb, input blend_t blend,
                                  input int n, input logic force_alpha, input channel_t alpha);
                int acc1;
                int acc2;
                int stall;
                acc1  = 0;
                acc2  = 0;
                stall = 0;
                @(negedge clk);
                i_argb_mode = argb;
                i_blend     = blend;
                while ((acc1 < n || acc2 < n || exp_q.size() > 0) && stall < STALL_LIMIT) begin
                        i_src1_write = (acc1 < n) && ($urandom % 4 != 0);
                        i_src1_data  = $urandom;
                        if (force_alpha) begin
                                i_src1_data[31:24] = alpha;
                        end
                        if (i_src1_write && !o_src1_full) begin
                                src1_q.push_back(i_src1_data);
                                acc1++;
                        end
                        i_src2_write = (acc2 < n) && ($urandom % 4 != 0);
                        i_src2_data  = $urandom;
                        if (i_src2_write && !o_src2_full) begin
                                src2_q.push_back(i_src2_data);
                                acc2++;
                        end
                        pair_sources(argb, blend);
                        i_dst_read = !o_dst_empty && ($urandom % 2 == 0);
                        if (i_dst_read) begin
                                stall = 0;
                                if (exp_q.size() == 0) begin
                                        $display("test %s: DUT output a pixel with no pair behind it",
                                                 name);
                                        test_errors++;
                                end else begin
                                        check_pixel(name, exp_q.pop_front(), o_dst_data);
                                end
                        end else if (exp_q.size() > 0) begin
                                stall++;
                        end
                        @(negedge clk);
                end
                finish_test(name);
        endtask

        // fill with reads held off, then drain
        task automatic run_backpressure(input string name);
                int attempts;
                int stall;
                attempts = 0;
                stall    = 0;
                @(negedge clk);
                i_argb_mode = 1'b0;
                i_blend     = $urandom;
                i_dst_read  = 1'b0;
                while (!(o_src1_full && o_src2_full) && attempts < BP_MAX_WRITES) begin
                        i_src1_write = 1'b1;
                        i_src2_write = 1'b1;
                        i_src1_data  = $urandom;
                        i_src2_data  = $urandom;
                        if (!o_src1_full) begin
                                src1_q.push_back(i_src1_data);
                        end
                        if (!o_src2_full) begin
                                src2_q.push_back(i_src2_data);
                        end
                        pair_sources(i_argb_mode, i_blend);
                        attempts++;
                        @(negedge clk);
                end
                i_src1_write = 1'b0;
                i_src2_write = 1'b0;
                check_flag({name, " src1 full"}, 1'b1, o_src1_full);
                check_flag({name, " src2 full"}, 1'b1, o_src2_full);
                // drain at full rate
                while (exp_q.size() > 0 && stall < STALL_LIMIT) begin
                        i_dst_read = !o_dst_empty;
                        if (i_dst_read) begin
                                stall = 0;
                                check_pixel(name, exp_q.pop_front(), o_dst_data);
                        end else begin
                                stall++;
                        end
                        @(negedge clk);
                end
                finish_test(name);
        endtask

        ////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////

        initial begin
                int unsigned seed;
                seed         = $urandom(32'he10445e1);
                i_argb_mode  = 1'b0;
                i_blend      = '0;
                i_src1_write = 1'b0;
                i_src2_write = 1'b0;
                i_src1_data  = '0;
                i_src2_data  = '0;
                i_dst_read   = 1'b0;
                cycle_count  = 0;
                test_errors  = 0;
                tests_passed = 0;
                tests_failed = 0;

                @(posedge rst_n);
                @(negedge clk);
                check_flag("reset src1 full", 1'b0, o_src1_full);
                check_flag("reset src2 full", 1'b0, o_src2_full);
                finish_test("reset");

                run_stream("global factor", 1'b0, $urandom, RANDOM_PIXELS, 1'b0, 8'h00);
                run_stream("argb mode", 1'b1, $urandom, RANDOM_PIXELS, 1'b0, 8'h00);

                // upper bits of the setting word must not matter
                run_stream("global factor 0", 1'b0, $urandom & 32'hffff_ff00, EXTREME_PIXELS,
                           1'b0, 8'h00);
                run_stream("global factor 255", 1'b0, $urandom | 32'h0000_00ff, EXTREME_PIXELS,
                           1'b0, 8'h00);
                run_stream("argb alpha 0", 1'b1, $urandom, EXTREME_PIXELS, 1'b1, 8'h00);
                run_stream("argb alpha 255", 1'b1, $urandom, EXTREME_PIXELS, 1'b1, 8'hff);

                run_backpressure("backpressure");

                $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
                if (tests_failed == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/gpu_pkg.sv
rtl/gpu_fifo.sv
rtl/gpu_blender.sv
rtl/gpu_blend_top.sv
sim/tb_clock_gen.sv
sim/tb_gpu_blend.sv
